/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // geometry fixed by the RV32I ISA
    localparam int xlen      = 32;
    localparam int reg_count = 32;
    localparam int tag_width = 8;

    typedef logic [$clog2(reg_count)-1:0] reg_addr_t;
    typedef logic [6:0]                   opcode_t;

    // RV32I major opcodes
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;
    // empty slot, also what a bubble looks like to the hazard logic
    localparam opcode_t op_nop    = 7'b0000000;

    // source of an execute operand
    typedef enum logic [1:0] {
        none      = 2'b00,
        mem       = 2'b01,
        writeback = 2'b10
    } forward_type;

    // decoded instruction as it arrives at the fetch port
    typedef struct packed {
        opcode_t              opcode;
        reg_addr_t            rs1;
        reg_addr_t            rs2;
        reg_addr_t            rd;
        logic                 reg_write;
        logic                 taken;
        logic [xlen-1:0]      result;
        logic [tag_width-1:0] tag;
    } instr_t;

    // one pipeline stage register
    typedef struct packed {
        logic   valid;
        instr_t instr;
    } stage_t;

    // operands consumed in execute
    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        logic [xlen-1:0]      operand_a;
        logic [xlen-1:0]      operand_b;
    } ex_report_t;

    // writeback port
    typedef struct packed {
        logic                 valid;
        reg_addr_t            rd;
        logic [xlen-1:0]      data;
        logic [tag_width-1:0] tag;
    } retire_t;

endpackage

`default_nettype wire

/* hazard/hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    // decode stage sources
    input  wire logic                [4:0] d_rs1,
    input  wire logic                [4:0] d_rs2,
    input  wire pipe_pkg::opcode_t         d_opcode,
    // execute stage
    input  wire pipe_pkg::reg_addr_t       e_rs1,
    input  wire pipe_pkg::reg_addr_t       e_rs2,
    input  wire pipe_pkg::reg_addr_t       e_rd,
    input  wire pipe_pkg::opcode_t         e_opcode,
    // memory stage
    input  wire logic                      m_reg_write,
    input  wire pipe_pkg::reg_addr_t       m_rd,
    input  wire pipe_pkg::opcode_t         m_opcode,
    // writeback stage
    input  wire logic                      w_reg_write,
    input  wire pipe_pkg::reg_addr_t       w_rd,
    input  wire pipe_pkg::opcode_t         w_opcode,

    input  wire logic                      cache_stall,

    // execute operand muxes
    output pipe_pkg::forward_type          fwd_a,
    output pipe_pkg::forward_type          fwd_b,

    output logic                           pc_en,
    output logic                           f_d_en,
    output logic                           d_e_en,
    output logic                           e_m_en,
    output logic                           m_w_en,
    output logic                           no_op,

    // control hazard, resolved in execute
    input  wire logic                      branch,
    input  wire logic                      branch_taken,
    input  wire logic                      jump,
    output logic                           pc_src,
    output logic                           flush
);

    logic d_uses_rs1;
    logic d_uses_rs2;
    logic e_uses_rs1;
    logic e_uses_rs2;
    logic m_writes;
    logic w_writes;
    logic load_use;
    logic front_en;

    function automatic logic reads_rs1(input pipe_pkg::opcode_t opcode);
        return !(opcode inside {pipe_pkg::op_lui, pipe_pkg::op_auipc,
                                pipe_pkg::op_jal, pipe_pkg::op_nop});
    endfunction

    function automatic logic reads_rs2(input pipe_pkg::opcode_t opcode);
        return opcode inside {pipe_pkg::op_branch, pipe_pkg::op_store, pipe_pkg::op_reg};
    endfunction

    // stores and branches carry an rd field but never write it
    function automatic logic writes_rd(input pipe_pkg::opcode_t opcode, input logic we);
        return we && !(opcode inside {pipe_pkg::op_store, pipe_pkg::op_branch,
                                      pipe_pkg::op_nop});
    endfunction

    always_comb begin
        d_uses_rs1 = reads_rs1(d_opcode);
        d_uses_rs2 = reads_rs2(d_opcode);
        e_uses_rs1 = reads_rs1(e_opcode);
        e_uses_rs2 = reads_rs2(e_opcode);
        m_writes   = writes_rd(m_opcode, m_reg_write);
        w_writes   = writes_rd(w_opcode, w_reg_write);
    end

    // load result not ready until memory, so a dependent in decode waits one cycle
    assign load_use = (e_opcode == pipe_pkg::op_load) && (e_rd != '0) &&
                      ((d_uses_rs1 && d_rs1 == e_rd) || (d_uses_rs2 && d_rs2 == e_rd));

    assign front_en = !(load_use || cache_stall);

    // front freezes, execute drains into memory and a bubble fills D/E
    always_comb begin
        pc_en  = front_en;
        f_d_en = front_en;
        d_e_en = front_en;
        e_m_en = 1'b1;
        m_w_en = 1'b1;
        no_op  = !front_en;
    end

    // memory holds the younger result so it wins over writeback
    function automatic pipe_pkg::forward_type select_fwd(
        input pipe_pkg::reg_addr_t src,
        input logic                used
    );
        pipe_pkg::forward_type sel;
        sel = pipe_pkg::none;
        if (used && m_writes && src == m_rd) begin
            sel = pipe_pkg::mem;
        end else if (used && w_writes && src == w_rd) begin
            sel = pipe_pkg::writeback;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = select_fwd(e_rs1, e_uses_rs1);
        fwd_b = select_fwd(e_rs2, e_uses_rs2);
    end

    // no prediction, so every taken branch and every jump redirects
    always_comb begin
        pc_src = (branch && branch_taken) || jump;
        flush  = pc_src;
    end

    // execute must really hold a branch or jump whenever a flush goes out
    always_comb begin
        assert (!flush || e_opcode inside {pipe_pkg::op_branch, pipe_pkg::op_jal,
                                            pipe_pkg::op_jalr})
            else $error("flush raised with no branch or jump in execute");
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire pipe_pkg::reg_addr_t       rd_addr_a,
    input  wire pipe_pkg::reg_addr_t       rd_addr_b,
    output logic [pipe_pkg::xlen-1:0]      rd_data_a,
    output logic [pipe_pkg::xlen-1:0]      rd_data_b,
    input  wire logic                      wr_en,
    input  wire pipe_pkg::reg_addr_t       wr_addr,
    input  wire logic [pipe_pkg::xlen-1:0] wr_data
);

    // x0 has no storage and always reads as zero
    logic [pipe_pkg::xlen-1:0] regs [1:pipe_pkg::reg_count-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < pipe_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle write shows through so decode sees the writeback result
    function automatic logic [pipe_pkg::xlen-1:0] read_port(input pipe_pkg::reg_addr_t addr);
        logic [pipe_pkg::xlen-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && addr == wr_addr) begin
            value = wr_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

    // the tracker strips reg_write from x0 destinations at fetch
    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> wr_addr != '0)
        else $error("write to x0 reached the register file");

endmodule

`default_nettype wire

/* rtl/pipe_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_tracker (
    input  wire logic                      clk,
    input  wire logic                      rst_n,

    input  wire logic                      fetch_valid,
    input  wire pipe_pkg::instr_t          fetch_instr,

    // from the hazard unit
    input  wire logic                      pc_en,
    input  wire logic                      f_d_en,
    input  wire logic                      d_e_en,
    input  wire logic                      e_m_en,
    input  wire logic                      m_w_en,
    input  wire logic                      no_op,
    input  wire logic                      flush,
    input  var  pipe_pkg::forward_type     fwd_a,
    input  var  pipe_pkg::forward_type     fwd_b,

    // to the hazard unit
    output pipe_pkg::reg_addr_t            d_rs1,
    output pipe_pkg::reg_addr_t            d_rs2,
    output pipe_pkg::opcode_t              d_opcode,
    output pipe_pkg::reg_addr_t            e_rs1,
    output pipe_pkg::reg_addr_t            e_rs2,
    output pipe_pkg::reg_addr_t            e_rd,
    output pipe_pkg::opcode_t              e_opcode,
    output logic                           m_reg_write,
    output pipe_pkg::reg_addr_t            m_rd,
    output pipe_pkg::opcode_t              m_opcode,
    output logic                           w_reg_write,
    output pipe_pkg::reg_addr_t            w_rd,
    output pipe_pkg::opcode_t              w_opcode,
    output logic                           branch,
    output logic                           branch_taken,
    output logic                           jump,

    // register file
    output pipe_pkg::reg_addr_t            rf_rd_addr_a,
    output pipe_pkg::reg_addr_t            rf_rd_addr_b,
    input  wire logic [pipe_pkg::xlen-1:0] rf_rd_data_a,
    input  wire logic [pipe_pkg::xlen-1:0] rf_rd_data_b,
    output logic                           rf_wr_en,
    output pipe_pkg::reg_addr_t            rf_wr_addr,
    output logic [pipe_pkg::xlen-1:0]      rf_wr_data,

    output pipe_pkg::ex_report_t           ex_out,
    output pipe_pkg::retire_t              retire
);

    pipe_pkg::stage_t          f_d;
    pipe_pkg::stage_t          d_e;
    pipe_pkg::stage_t          e_m;
    pipe_pkg::stage_t          m_w;
    pipe_pkg::instr_t          fetched;
    logic [pipe_pkg::xlen-1:0] d_e_op_a;
    logic [pipe_pkg::xlen-1:0] d_e_op_b;
    logic [pipe_pkg::xlen-1:0] ex_op_a;
    logic [pipe_pkg::xlen-1:0] ex_op_b;

    // rd of x0 never writes, which keeps x0 out of forwarding
    always_comb begin
        fetched = fetch_instr;
        if (fetch_instr.rd == '0) begin
            fetched.reg_write = 1'b0;
        end
    end

    // flush outranks the enables in both front registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            f_d <= '0;
        end else if (flush) begin
            f_d.valid <= 1'b0;
        end else if (f_d_en) begin
            f_d.valid <= fetch_valid && pc_en;
            f_d.instr <= fetched;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_e <= '0;
        end else if (flush || no_op) begin
            d_e.valid <= 1'b0;
        end else if (d_e_en) begin
            d_e <= f_d;
        end
    end

    always_ff @(posedge clk) begin
        if (d_e_en) begin
            d_e_op_a <= rf_rd_data_a;
            d_e_op_b <= rf_rd_data_b;
        end
    end

    // back of the pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_m <= '0;
            m_w <= '0;
        end else begin
            if (e_m_en) begin
                e_m <= d_e;
            end
            if (m_w_en) begin
                m_w <= e_m;
            end
        end
    end

    function automatic logic [pipe_pkg::xlen-1:0] pick_operand(
        input pipe_pkg::forward_type      sel,
        input logic [pipe_pkg::xlen-1:0]  latched
    );
        logic [pipe_pkg::xlen-1:0] value;
        case (sel)
            pipe_pkg::mem:       value = e_m.instr.result;
            pipe_pkg::writeback: value = m_w.instr.result;
            default:             value = latched;
        endcase
        return value;
    endfunction

    always_comb begin
        ex_op_a = pick_operand(fwd_a, d_e_op_a);
        ex_op_b = pick_operand(fwd_b, d_e_op_b);
    end

    // bubbles look like nops so they never match anything
    assign d_rs1    = f_d.instr.rs1;
    assign d_rs2    = f_d.instr.rs2;
    assign d_opcode = f_d.valid ? f_d.instr.opcode : pipe_pkg::op_nop;
    assign e_rs1    = d_e.instr.rs1;
    assign e_rs2    = d_e.instr.rs2;
    assign e_rd     = d_e.instr.rd;
    assign e_opcode = d_e.valid ? d_e.instr.opcode : pipe_pkg::op_nop;

    assign m_reg_write = e_m.valid && e_m.instr.reg_write;
    assign m_rd        = e_m.instr.rd;
    assign m_opcode    = e_m.valid ? e_m.instr.opcode : pipe_pkg::op_nop;
    assign w_reg_write = m_w.valid && m_w.instr.reg_write;
    assign w_rd        = m_w.instr.rd;
    assign w_opcode    = m_w.valid ? m_w.instr.opcode : pipe_pkg::op_nop;

    assign branch       = d_e.valid && d_e.instr.opcode == pipe_pkg::op_branch;
    assign jump         = d_e.valid && (d_e.instr.opcode == pipe_pkg::op_jal ||
                                        d_e.instr.opcode == pipe_pkg::op_jalr);
    assign branch_taken = d_e.instr.taken;

    assign rf_rd_addr_a = f_d.instr.rs1;
    assign rf_rd_addr_b = f_d.instr.rs2;
    assign rf_wr_en     = w_reg_write;
    assign rf_wr_addr   = m_w.instr.rd;
    assign rf_wr_data   = m_w.instr.result;

    // reports are taken on the edge that ends each stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_out <= '0;
            retire <= '0;
        end else begin
            ex_out.valid     <= d_e.valid && e_m_en;
            ex_out.tag       <= d_e.instr.tag;
            ex_out.operand_a <= ex_op_a;
            ex_out.operand_b <= ex_op_b;
            retire.valid     <= m_w.valid;
            retire.rd        <= rf_wr_en ? m_w.instr.rd : '0;
            retire.data      <= rf_wr_en ? m_w.instr.result : '0;
            retire.tag       <= m_w.instr.tag;
        end
    end

    // an instruction must never sit in execute and memory at once
    assert property (@(posedge clk) disable iff (!rst_n)
        d_e.valid && e_m.valid |-> d_e.instr.tag != e_m.instr.tag)
        else $error("tag %0d duplicated across D/E and E/M", d_e.instr.tag);

endmodule

`default_nettype wire

/* rtl/pipe_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_top (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             fetch_valid,
    input  wire pipe_pkg::instr_t fetch_instr,
    output logic                  fetch_ready,
    input  wire logic             cache_stall,
    output pipe_pkg::ex_report_t  ex_out,
    output pipe_pkg::retire_t     retire
);

    pipe_pkg::reg_addr_t       d_rs1;
    pipe_pkg::reg_addr_t       d_rs2;
    pipe_pkg::opcode_t         d_opcode;
    pipe_pkg::reg_addr_t       e_rs1;
    pipe_pkg::reg_addr_t       e_rs2;
    pipe_pkg::reg_addr_t       e_rd;
    pipe_pkg::opcode_t         e_opcode;
    logic                      m_reg_write;
    pipe_pkg::reg_addr_t       m_rd;
    pipe_pkg::opcode_t         m_opcode;
    logic                      w_reg_write;
    pipe_pkg::reg_addr_t       w_rd;
    pipe_pkg::opcode_t         w_opcode;
    logic                      branch;
    logic                      branch_taken;
    logic                      jump;

    logic                      f_d_en;
    logic                      d_e_en;
    logic                      e_m_en;
    logic                      m_w_en;
    logic                      no_op;
    logic                      flush;
    pipe_pkg::forward_type     fwd_a;
    pipe_pkg::forward_type     fwd_b;

    pipe_pkg::reg_addr_t       rf_rd_addr_a;
    pipe_pkg::reg_addr_t       rf_rd_addr_b;
    logic [pipe_pkg::xlen-1:0] rf_rd_data_a;
    logic [pipe_pkg::xlen-1:0] rf_rd_data_b;
    logic                      rf_wr_en;
    pipe_pkg::reg_addr_t       rf_wr_addr;
    logic [pipe_pkg::xlen-1:0] rf_wr_data;

    pipe_tracker u_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_instr  (fetch_instr),
        .pc_en        (fetch_ready),
        .f_d_en       (f_d_en),
        .d_e_en       (d_e_en),
        .e_m_en       (e_m_en),
        .m_w_en       (m_w_en),
        .no_op        (no_op),
        .flush        (flush),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .d_rs1        (d_rs1),
        .d_rs2        (d_rs2),
        .d_opcode     (d_opcode),
        .e_rs1        (e_rs1),
        .e_rs2        (e_rs2),
        .e_rd         (e_rd),
        .e_opcode     (e_opcode),
        .m_reg_write  (m_reg_write),
        .m_rd         (m_rd),
        .m_opcode     (m_opcode),
        .w_reg_write  (w_reg_write),
        .w_rd         (w_rd),
        .w_opcode     (w_opcode),
        .branch       (branch),
        .branch_taken (branch_taken),
        .jump         (jump),
        .rf_rd_addr_a (rf_rd_addr_a),
        .rf_rd_addr_b (rf_rd_addr_b),
        .rf_rd_data_a (rf_rd_data_a),
        .rf_rd_data_b (rf_rd_data_b),
        .rf_wr_en     (rf_wr_en),
        .rf_wr_addr   (rf_wr_addr),
        .rf_wr_data   (rf_wr_data),
        .ex_out       (ex_out),
        .retire       (retire)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rf_rd_addr_a),
        .rd_addr_b (rf_rd_addr_b),
        .rd_data_a (rf_rd_data_a),
        .rd_data_b (rf_rd_data_b),
        .wr_en     (rf_wr_en),
        .wr_addr   (rf_wr_addr),
        .wr_data   (rf_wr_data)
    );

    // pc_src stays open since the fetch source owns the redirect
    hazard_unit u_hazard (
        .d_rs1        (d_rs1),
        .d_rs2        (d_rs2),
        .d_opcode     (d_opcode),
        .e_rs1        (e_rs1),
        .e_rs2        (e_rs2),
        .e_rd         (e_rd),
        .e_opcode     (e_opcode),
        .m_reg_write  (m_reg_write),
        .m_rd         (m_rd),
        .m_opcode     (m_opcode),
        .w_reg_write  (w_reg_write),
        .w_rd         (w_rd),
        .w_opcode     (w_opcode),
        .cache_stall  (cache_stall),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .pc_en        (fetch_ready),
        .f_d_en       (f_d_en),
        .d_e_en       (d_e_en),
        .e_m_en       (e_m_en),
        .m_w_en       (m_w_en),
        .no_op        (no_op),
        .branch       (branch),
        .branch_taken (branch_taken),
        .jump         (jump),
        .pc_src       (),
        .flush        (flush)
    );

endmodule

`default_nettype wire

/* bench/pipe_ctrl_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_tb;

    localparam int num_instr   = 400;
    localparam int cycle_limit = 20 * num_instr;
    localparam int tag_count   = 1 << pipe_pkg::tag_width;

    localparam int t_reset   = 0;
    localparam int t_oper    = 1;
    localparam int t_retire  = 2;
    localparam int t_flush   = 3;
    localparam int t_load    = 4;
    localparam int t_stall   = 5;
    localparam int num_tests = 6;

    logic                 clk;
    logic                 rst_n;
    logic                 fetch_valid;
    pipe_pkg::instr_t     fetch_instr;
    logic                 fetch_ready;
    logic                 cache_stall;
    pipe_pkg::ex_report_t ex_out;
    pipe_pkg::retire_t    retire;

    // reference register file, written in program order as instructions execute
    logic [pipe_pkg::xlen-1:0]      model [pipe_pkg::reg_count];
    pipe_pkg::instr_t               info [tag_count];
    int                             acc_cycle [tag_count];
    int                             ex_cycle [tag_count];
    logic [pipe_pkg::tag_width-1:0] pending [$];
    logic [pipe_pkg::tag_width-1:0] exec_q [$];

    pipe_pkg::instr_t               cur;
    logic [pipe_pkg::tag_width-1:0] next_tag;
    logic [pipe_pkg::tag_width-1:0] prev_tag;
    int                             cycle;
    int                             last_stall_cycle;
    int                             stall_left;
    int                             skip_left;
    int                             retired;
    logic                           edge_stall;
    logic                           prev_ok;
    logic                           running;
    logic                           timed_out;
    int                             checks [num_tests];
    int                             errors [num_tests];
    int                             tests_passed;
    int                             tests_failed;

    pipe_ctrl_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .fetch_ready (fetch_ready),
        .cache_stall (cache_stall),
        .ex_out      (ex_out),
        .retire      (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic string test_name(input int t);
        case (t)
            t_reset:  return "reset_state";
            t_oper:   return "operands";
            t_retire: return "retire_order";
            t_flush:  return "flush_loss";
            t_load:   return "load_use_timing";
            default:  return "stall_freeze";
        endcase
    endfunction

    // RV32I formats that carry a destination
    function automatic logic has_dest(input pipe_pkg::opcode_t op);
        case (op)
            pipe_pkg::op_lui, pipe_pkg::op_auipc, pipe_pkg::op_jal, pipe_pkg::op_jalr,
            pipe_pkg::op_load, pipe_pkg::op_imm, pipe_pkg::op_reg: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic uses_src1(input pipe_pkg::opcode_t op);
        case (op)
            pipe_pkg::op_jalr, pipe_pkg::op_branch, pipe_pkg::op_load, pipe_pkg::op_store,
            pipe_pkg::op_imm, pipe_pkg::op_reg: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic uses_src2(input pipe_pkg::opcode_t op);
        case (op)
            pipe_pkg::op_branch, pipe_pkg::op_store, pipe_pkg::op_reg: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic updates_reg(input pipe_pkg::instr_t ins);
        return has_dest(ins.opcode) && ins.rd != '0;
    endfunction

    function automatic logic redirects(input pipe_pkg::instr_t ins);
        return ins.opcode == pipe_pkg::op_jal || ins.opcode == pipe_pkg::op_jalr ||
               (ins.opcode == pipe_pkg::op_branch && ins.taken);
    endfunction

    // x0..x7 most of the time so that dependences are dense
    function automatic pipe_pkg::reg_addr_t pick_reg();
        if ($urandom % 8 != 0) begin
            return 5'($urandom % 8);
        end
        return 5'($urandom % 32);
    endfunction

    function automatic pipe_pkg::instr_t make_instr(input logic [pipe_pkg::tag_width-1:0] tag);
        pipe_pkg::instr_t ins;
        int unsigned      roll;
        int unsigned      coin;
        roll = $urandom % 100;
        if (roll < 25) ins.opcode = pipe_pkg::op_reg;
        else if (roll < 45) ins.opcode = pipe_pkg::op_imm;
        else if (roll < 65) ins.opcode = pipe_pkg::op_load;
        else if (roll < 75) ins.opcode = pipe_pkg::op_store;
        else if (roll < 85) ins.opcode = pipe_pkg::op_branch;
        else if (roll < 89) ins.opcode = pipe_pkg::op_lui;
        else if (roll < 91) ins.opcode = pipe_pkg::op_auipc;
        else if (roll < 96) ins.opcode = pipe_pkg::op_jal;
        else ins.opcode = pipe_pkg::op_jalr;
        ins.rs1       = pick_reg();
        ins.rs2       = pick_reg();
        ins.rd        = pick_reg();
        ins.reg_write = has_dest(ins.opcode);
        coin          = $urandom % 2;
        ins.taken     = ins.opcode == pipe_pkg::op_branch && coin == 1;
        ins.result    = $urandom;
        ins.tag       = tag;
        return ins;
    endfunction

    task automatic check_value(input int test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks[test] = checks[test] + 1;
        if (expected !== actual) begin
            errors[test] = errors[test] + 1;
            $display("FAIL %s %s: expected %0h, actual %0h", test_name(test), what,
                     expected, actual);
        end
    endtask

    // one rising edge of stimulus, handshake sampled before the edge updates anything
    task automatic drive_edge();
        cycle      = cycle + 1;
        edge_stall = cache_stall;
        if (edge_stall) begin
            last_stall_cycle = cycle;
        end
        if (fetch_valid && fetch_ready) begin
            info[cur.tag]      = cur;
            acc_cycle[cur.tag] = cycle;
            pending.push_back(cur.tag);
            next_tag = next_tag + 1'b1;
            cur      = make_instr(next_tag);
        end
        fetch_valid <= 1'b1;
        fetch_instr <= cur;
        if (stall_left > 0) begin
            stall_left = stall_left - 1;
            cache_stall <= 1'b1;
        end else if ($urandom % 12 == 0) begin
            stall_left = int'($urandom % 4);
            cache_stall <= 1'b1;
        end else begin
            cache_stall <= 1'b0;
        end
    endtask

    task automatic note_execute(input pipe_pkg::ex_report_t rep);
        logic [pipe_pkg::tag_width-1:0] tag;
        pipe_pkg::instr_t               ins;
        pipe_pkg::instr_t               prev;
        logic                           dep;
        // younger slots squashed by the last redirect
        while (skip_left > 0 && pending.size() > 0) begin
            void'(pending.pop_front());
            skip_left = skip_left - 1;
            prev_ok   = 1'b0;
        end
        if (pending.size() == 0) begin
            errors[t_flush] = errors[t_flush] + 1;
            $display("ex_out reported tag %0d with no instruction in flight", rep.tag);
            return;
        end
        tag = pending.pop_front();
        ins = info[tag];
        check_value(t_flush, "execute tag", 32'(tag), 32'(rep.tag));
        if (uses_src1(ins.opcode)) begin
            check_value(t_oper, "operand_a", model[ins.rs1], rep.operand_a);
        end
        if (uses_src2(ins.opcode)) begin
            check_value(t_oper, "operand_b", model[ins.rs2], rep.operand_b);
        end
        // back to back after a load, with no cache stall since the load was fetched
        prev = info[prev_tag];
        if (prev_ok && prev.opcode == pipe_pkg::op_load &&
            acc_cycle[tag] == acc_cycle[prev_tag] + 1 &&
            last_stall_cycle < acc_cycle[prev_tag]) begin
            dep = prev.rd != '0 && ((uses_src1(ins.opcode) && ins.rs1 == prev.rd) ||
                                    (uses_src2(ins.opcode) && ins.rs2 == prev.rd));
            check_value(t_load, "execute gap", dep ? 32'd2 : 32'd1,
                        32'(cycle - ex_cycle[prev_tag]));
        end
        if (updates_reg(ins)) begin
            model[ins.rd] = ins.result;
        end
        ex_cycle[tag] = cycle;
        exec_q.push_back(tag);
        prev_ok  = 1'b1;
        prev_tag = tag;
        // a stalled front has no fetch on the redirect edge, so only F/D is lost
        if (redirects(ins)) begin
            skip_left = edge_stall ? 1 : 2;
        end
    endtask

    task automatic note_retire(input pipe_pkg::retire_t ret);
        logic [pipe_pkg::tag_width-1:0] tag;
        pipe_pkg::instr_t               ins;
        logic                           wr;
        int                             test;
        retired = retired + 1;
        if (exec_q.size() == 0) begin
            errors[t_retire] = errors[t_retire] + 1;
            $display("retire reported tag %0d that never executed", ret.tag);
            return;
        end
        tag = exec_q.pop_front();
        ins = info[tag];
        wr  = updates_reg(ins);
        check_value(t_retire, "retire tag", 32'(tag), 32'(ret.tag));
        check_value(t_retire, "retire rd", wr ? 32'(ins.rd) : 32'd0, 32'(ret.rd));
        check_value(t_retire, "retire data", wr ? ins.result : 32'd0, ret.data);
        // memory and writeback keep moving through a cache stall
        test = last_stall_cycle > ex_cycle[tag] ? t_stall : t_retire;
        check_value(test, "retire latency", 32'd2, 32'(cycle - ex_cycle[tag]));
    endtask

    task automatic report_test(input int t);
        if (checks[t] == 0) begin
            tests_failed = tests_failed + 1;
            $display("test %s: no checks were exercised", test_name(t));
        end else if (errors[t] == 0) begin
            tests_passed = tests_passed + 1;
            $display("test %s: %0d checks passed", test_name(t), checks[t]);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d of %0d checks failed", test_name(t), errors[t], checks[t]);
        end
    endtask

    always @(negedge clk) begin
        if (running) begin
            if (cache_stall) begin
                check_value(t_stall, "fetch_ready", 32'd0, 32'(fetch_ready));
            end
            if (ex_out.valid) begin
                note_execute(ex_out);
            end
            if (retire.valid) begin
                note_retire(retire);
            end
        end
    end

    initial begin
        void'($urandom(59));
        rst_n            = 1'b0;
        fetch_valid      = 1'b0;
        fetch_instr      = '0;
        cache_stall      = 1'b0;
        running          = 1'b0;
        timed_out        = 1'b0;
        cycle            = 0;
        last_stall_cycle = 0;
        stall_left       = 0;
        skip_left        = 0;
        retired          = 0;
        edge_stall       = 1'b0;
        prev_ok          = 1'b0;
        prev_tag         = '0;
        tests_passed     = 0;
        tests_failed     = 0;
        for (int i = 0; i < pipe_pkg::reg_count; i++) begin
            model[i] = '0;
        end
        for (int t = 0; t < num_tests; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        next_tag = '0;
        cur      = make_instr(next_tag);

        repeat (5) @(posedge clk);
        rst_n   <= 1'b1;
        running = 1'b1;
        @(negedge clk);
        check_value(t_reset, "fetch_ready", 32'd1, 32'(fetch_ready));
        check_value(t_reset, "ex_out valid", 32'd0, 32'(ex_out.valid));
        check_value(t_reset, "retire valid", 32'd0, 32'(retire.valid));
        report_test(t_reset);

        while (retired < num_instr && cycle < cycle_limit) begin
            @(posedge clk);
            drive_edge();
        end
        if (retired < num_instr) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                     retired, num_instr, cycle);
        end

        for (int t = 1; t < num_tests; t++) begin
            report_test(t);
        end
        $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (!timed_out && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
common/pipe_pkg.sv
hazard/hazard_unit.sv
rtl/reg_file.sv
rtl/pipe_tracker.sv
rtl/pipe_ctrl_top.sv
bench/pipe_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pipeline control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module pipe_ctrl_tb -f verilog.f -o sim_pipe
./obj_dir/sim_pipe | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
